/* source/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    // operand and result width
    localparam int data_width = 32;

    // shift amount covers 0..31
    localparam int shift_width = 5;

    // one iteration per operand bit
    localparam int muldiv_steps = 32;

    typedef logic [data_width-1:0] alu_word_t;

    // opcode field of the execute stage
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_sll = 4'd4,
        op_sra = 4'd5,
        op_mul = 4'd6,
        op_div = 4'd7,
        op_xor = 4'd8
    } alu_op_e;

    // handshake controller
    // idle accepts, mul and div wait on a unit, hold presents the result
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_mul  = 2'd1,
        st_div  = 2'd2,
        st_hold = 2'd3
    } alu_state_e;

endpackage

`default_nettype wire

/* source/cla_adder.sv */
`default_nettype none

module cla_adder (
    input  wire alu_pkg::alu_word_t a,
    input  wire alu_pkg::alu_word_t b,
    input  wire logic               carry_in,
    output alu_pkg::alu_word_t      sum,
    output alu_pkg::alu_word_t      and_out,
    output alu_pkg::alu_word_t      or_out,
    output logic                    carry_out
);
    import alu_pkg::*;

    // per-bit generate and propagate
    alu_word_t gen;
    alu_word_t prop;
    // carry into every bit position
    alu_word_t carry;

    // 4-bit groups, eight of them for a 32-bit word
    logic [data_width/4-1:0] grp_gen;
    logic [data_width/4-1:0] grp_prop;
    logic [data_width/4:0]   grp_carry;

    assign gen  = a & b;
    assign prop = a | b;

    // logic ops come straight from g and p
    assign and_out = gen;
    assign or_out  = prop;

    // first level, group g and p
    always_comb begin
        for (int grp = 0; grp < data_width / 4; grp++) begin
            grp_prop[grp] = &prop[grp*4 +: 4];
            grp_gen[grp]  = gen[grp*4+3]
                          | (prop[grp*4+3] & gen[grp*4+2])
                          | (prop[grp*4+3] & prop[grp*4+2] & gen[grp*4+1])
                          | (&prop[grp*4+1 +: 3] & gen[grp*4]);
        end
    end

    // second level
    // every group carry is a flat sum of products over all lower groups
    always_comb begin
        logic term;
        logic span;
        grp_carry[0] = carry_in;
        for (int i = 0; i < data_width / 4; i++) begin
            term = 1'b0;
            span = 1'b1;
            for (int j = i; j >= 0; j--) begin
                term = term | (span & grp_gen[j]);
                span = span & grp_prop[j];
            end
            grp_carry[i+1] = term | (span & carry_in);
        end
    end

    // bit carries inside each group, again without rippling
    always_comb begin
        logic term;
        logic span;
        for (int grp = 0; grp < data_width / 4; grp++) begin
            for (int k = 0; k < 4; k++) begin
                term = 1'b0;
                span = 1'b1;
                for (int j = k - 1; j >= 0; j--) begin
                    term = term | (span & gen[grp*4+j]);
                    span = span & prop[grp*4+j];
                end
                carry[grp*4+k] = term | (span & grp_carry[grp]);
            end
        end
    end

    // half-sum from the raw inputs, p here is the OR form
    assign sum       = a ^ b ^ carry;
    assign carry_out = grp_carry[data_width/4];

endmodule

`default_nettype wire

/* source/barrel_shifter.sv */
`default_nettype none

module barrel_shifter (
    input  wire alu_pkg::alu_word_t               value,
    input  wire logic [alu_pkg::shift_width-1:0]  shift_amount,
    output alu_pkg::alu_word_t                    left_logical,
    output alu_pkg::alu_word_t                    right_arith
);
    import alu_pkg::*;

    // stage 0 is the input, stage shift_width the final value
    alu_word_t left_stage  [0:shift_width];
    alu_word_t right_stage [0:shift_width];

    assign left_stage[0]  = value;
    assign right_stage[0] = value;

    // log shifter
    // stage s moves by 2**s when bit s of the amount is set
    for (genvar s = 0; s < shift_width; s++) begin : g_stage

        // left chain, zeros enter at the bottom
        assign left_stage[s+1] = shift_amount[s]
            ? {left_stage[s][data_width-1-(2**s):0], {(2**s){1'b0}}}
            : left_stage[s];

        // right chain, copies of the sign enter at the top
        assign right_stage[s+1] = shift_amount[s]
            ? {{(2**s){right_stage[s][data_width-1]}},
               right_stage[s][data_width-1:2**s]}
            : right_stage[s];

    end

    // both chains run in parallel
    // alu picks the one it needs
    assign left_logical = left_stage[shift_width];
    assign right_arith  = right_stage[shift_width];

endmodule

`default_nettype wire

/* source/multiplier.sv */
`default_nettype none

module multiplier (
    input  wire logic               clock,
    input  wire logic               arst_n,
    input  wire logic               start,
    input  wire alu_pkg::alu_word_t multiplicand,
    input  wire alu_pkg::alu_word_t multiplier_in,
    output logic                    done,
    output alu_pkg::alu_word_t      product,
    output logic                    overflow
);
    import alu_pkg::*;

    logic                              busy;
    logic                              negate;
    logic [$clog2(muldiv_steps)-1:0]   step;
    logic                              last_step;

    // magnitudes, taken at start
    alu_word_t mcand_in_mag;
    alu_word_t mplier_in_mag;
    alu_word_t mcand_mag;

    // upper half is the running sum, lower half the multiplier bits left
    logic [2*data_width-1:0] acc;
    logic [2*data_width-1:0] acc_next;
    logic [data_width:0]     upper_sum;

    // the most-negative value maps to itself, still right as unsigned
    assign mcand_in_mag  = multiplicand[data_width-1] ? -multiplicand : multiplicand;
    assign mplier_in_mag = multiplier_in[data_width-1] ? -multiplier_in : multiplier_in;

    // add the multiplicand when the current multiplier bit is set
    assign upper_sum = {1'b0, acc[2*data_width-1:data_width]}
                     + {1'b0, mcand_mag & {data_width{acc[0]}}};
    // then shift right one, carry drops into the top
    assign acc_next  = {upper_sum, acc[data_width-1:1]};

    assign last_step = busy && (step == muldiv_steps - 1);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy   <= 1'b0;
            done   <= 1'b0;
            negate <= 1'b0;
            step   <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy   <= 1'b1;
                step   <= '0;
                negate <= multiplicand[data_width-1] ^ multiplier_in[data_width-1];
            end else if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            mcand_mag <= mcand_in_mag;
            acc       <= {{data_width{1'b0}}, mplier_in_mag};
        end else if (busy) begin
            // sign goes on together with the final add
            if (last_step && negate) begin
                acc <= -acc_next;
            end else begin
                acc <= acc_next;
            end
        end
    end

    assign product = acc[data_width-1:0];

    // top 33 bits must all match the sign of the low word
    assign overflow = !((&acc[2*data_width-1:data_width-1])
                     || (~|acc[2*data_width-1:data_width-1]));

    // alu only starts a unit from idle
    a_no_restart: assert property (@(posedge clock) disable iff (!arst_n)
        start |-> !busy);

endmodule

`default_nettype wire

/* source/divider.sv */
`default_nettype none

module divider (
    input  wire logic               clock,
    input  wire logic               arst_n,
    input  wire logic               start,
    input  wire alu_pkg::alu_word_t dividend,
    input  wire alu_pkg::alu_word_t divisor,
    output logic                    done,
    output alu_pkg::alu_word_t      quotient,
    output logic                    divide_by_zero
);
    import alu_pkg::*;

    logic                            busy;
    // extra cycle after the last step for the sign
    logic                            fixup;
    logic                            negate;
    logic                            zero_div;
    logic [$clog2(muldiv_steps)-1:0] step;
    logic                            last_step;

    alu_word_t dividend_mag;
    alu_word_t divisor_mag;
    alu_word_t dvs_mag;
    // partial remainder
    alu_word_t rem;
    // dividend bits shift out the top, quotient bits shift in the bottom
    alu_word_t quo;
    // trial subtract, top bit is the borrow
    logic [data_width+1:0] trial;

    assign dividend_mag = dividend[data_width-1] ? -dividend : dividend;
    assign divisor_mag  = divisor[data_width-1] ? -divisor : divisor;

    // bring down the next dividend bit and try the subtract
    assign trial = {1'b0, rem, quo[data_width-1]} - {2'b00, dvs_mag};

    assign last_step = busy && !fixup && (step == muldiv_steps - 1);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            fixup    <= 1'b0;
            done     <= 1'b0;
            negate   <= 1'b0;
            zero_div <= 1'b0;
            step     <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy     <= 1'b1;
                fixup    <= 1'b0;
                step     <= '0;
                // quotient sign, truncation toward zero
                negate   <= dividend[data_width-1] ^ divisor[data_width-1];
                zero_div <= (divisor == '0);
            end else if (fixup) begin
                fixup <= 1'b0;
                busy  <= 1'b0;
                done  <= 1'b1;
            end else if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin
                    fixup <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            dvs_mag <= divisor_mag;
            rem     <= '0;
            quo     <= dividend_mag;
        end else if (fixup) begin
            // zero divisor ran all steps anyway, all ones get dropped here
            if (zero_div) begin
                quo <= '0;
            end else if (negate) begin
                quo <= -quo;
            end
        end else if (busy) begin
            if (!trial[data_width+1]) begin
                rem <= trial[data_width-1:0];
                quo <= {quo[data_width-2:0], 1'b1};
            end else begin
                // restore, keep the shifted remainder
                rem <= {rem[data_width-2:0], quo[data_width-1]};
                quo <= {quo[data_width-2:0], 1'b0};
            end
        end
    end

    assign quotient       = quo;
    assign divide_by_zero = zero_div;

    // alu only starts a unit from idle
    a_no_restart: assert property (@(posedge clock) disable iff (!arst_n)
        start |-> !busy);

endmodule

`default_nettype wire

/* source/alu.sv */
`default_nettype none

module alu (
    input  wire logic                            clock,
    input  wire logic                            arst_n,
    input  wire logic                            in_valid,
    output logic                                 in_ready,
    input  wire alu_pkg::alu_op_e                op,
    input  wire alu_pkg::alu_word_t              operand_a,
    input  wire alu_pkg::alu_word_t              operand_b,
    input  wire logic [alu_pkg::shift_width-1:0] shift_amount,
    output logic                                 out_valid,
    input  wire logic                            out_ready,
    output alu_pkg::alu_word_t                   result,
    output logic                                 not_equal,
    output logic                                 less_than,
    output logic                                 overflow
);
    import alu_pkg::*;

    alu_state_e             state;
    logic                   accept;
    logic                   res_valid;
    logic                   load_result;
    logic                   mul_start;
    logic                   div_start;

    // operation latched at acceptance
    alu_op_e                op_q;
    alu_word_t              a_q;
    alu_word_t              b_q;
    logic [shift_width-1:0] shamt_q;

    alu_word_t adder_b, add_sum, and_res, or_res, sll_res, sra_res;
    logic      adder_cin, adder_cout, add_ovf;
    alu_word_t mul_product, div_quotient;
    logic      mul_done, mul_ovf, div_done, div_zero, div_wrap;

    alu_word_t next_result;
    logic      next_ne, next_lt, next_ovf;

    assign accept = in_valid && in_ready;

    always_ff @(posedge clock) begin
        if (accept) begin
            op_q    <= op;
            a_q     <= operand_a;
            b_q     <= operand_b;
            shamt_q <= shift_amount;
        end
    end

    // subtract as a + ~b + 1
    assign adder_cin = (op_q == op_sub);
    assign adder_b   = adder_cin ? ~b_q : b_q;

    cla_adder u_adder (
        .a         (a_q),
        .b         (adder_b),
        .carry_in  (adder_cin),
        .sum       (add_sum),
        .and_out   (and_res),
        .or_out    (or_res),
        .carry_out (adder_cout)
    );

    barrel_shifter u_shifter (
        .value        (a_q),
        .shift_amount (shamt_q),
        .left_logical (sll_res),
        .right_arith  (sra_res)
    );

    multiplier u_multiplier (
        .clock         (clock),
        .arst_n        (arst_n),
        .start         (mul_start),
        .multiplicand  (a_q),
        .multiplier_in (b_q),
        .done          (mul_done),
        .product       (mul_product),
        .overflow      (mul_ovf)
    );

    divider u_divider (
        .clock          (clock),
        .arst_n         (arst_n),
        .start          (div_start),
        .dividend       (a_q),
        .divisor        (b_q),
        .done           (div_done),
        .quotient       (div_quotient),
        .divide_by_zero (div_zero)
    );

    // carry into msb xor carry out of msb
    assign add_ovf = a_q[data_width-1] ^ adder_b[data_width-1]
                   ^ add_sum[data_width-1] ^ adder_cout;

    // most-negative / -1 wraps to itself
    assign div_wrap = (a_q == {1'b1, {(data_width-1){1'b0}}}) && (&b_q);

    // result mux
    always_comb begin
        next_result = '0;
        next_ne     = 1'b0;
        next_lt     = 1'b0;
        next_ovf    = 1'b0;
        case (op_q)
            op_add, op_sub: begin
                next_result = add_sum;
                next_ne     = |add_sum;
                // a sign flipped by overflow reverses the compare
                next_lt     = add_sum[data_width-1] ^ add_ovf;
                next_ovf    = add_ovf;
            end
            op_and: next_result = and_res;
            op_or:  next_result = or_res;
            op_xor: next_result = a_q ^ b_q;
            op_sll: next_result = sll_res;
            op_sra: next_result = sra_res;
            op_mul: begin
                next_result = mul_product;
                next_ovf    = mul_ovf;
            end
            op_div: begin
                next_result = div_quotient;
                next_ovf    = div_zero || div_wrap;
            end
            default: next_result = '0;
        endcase
    end

    // single-cycle ops land one cycle into hold, mul and div on done
    assign load_result = ((state == st_hold) && !res_valid)
                      || ((state == st_mul) && mul_done)
                      || ((state == st_div) && div_done);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            mul_start <= 1'b0;
            div_start <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            mul_start <= 1'b0;
            div_start <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        if (op == op_mul) begin
                            state     <= st_mul;
                            mul_start <= 1'b1;
                        end else if (op == op_div) begin
                            state     <= st_div;
                            div_start <= 1'b1;
                        end else begin
                            state <= st_hold;
                        end
                    end
                end
                st_mul:  if (mul_done) state <= st_hold;
                st_div:  if (div_done) state <= st_hold;
                st_hold: if (res_valid && out_ready) state <= st_idle;
            endcase
            if (load_result) begin
                res_valid <= 1'b1;
            end else if (res_valid && out_ready) begin
                res_valid <= 1'b0;
            end
        end
    end

    // output register
    always_ff @(posedge clock) begin
        if (load_result) begin
            result    <= next_result;
            not_equal <= next_ne;
            less_than <= next_lt;
            overflow  <= next_ovf;
        end
    end

    assign in_ready  = (state == st_idle);
    assign out_valid = res_valid;

    a_op_legal: assert property (@(posedge clock) disable iff (!arst_n)
        in_valid |-> (op <= op_xor));

    a_out_stable: assert property (@(posedge clock) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(result)
            && $stable({not_equal, less_than, overflow}));

endmodule

`default_nettype wire

/* verification/alu_tb.sv */
`default_nettype none

module alu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import alu_pkg::*;

    localparam int max_rows = 48;

    logic                   clock;
    logic                   arst_n;
    logic                   in_valid;
    logic                   in_ready;
    alu_op_e                op;
    alu_word_t              operand_a;
    alu_word_t              operand_b;
    logic [shift_width-1:0] shift_amount;
    logic                   out_valid;
    logic                   out_ready;
    alu_word_t              result;
    logic                   not_equal;
    logic                   less_than;
    logic                   overflow;

    // stimulus table, one entry per test
    string                  t_name  [max_rows];
    alu_op_e                t_op    [max_rows];
    alu_word_t              t_a     [max_rows];
    alu_word_t              t_b     [max_rows];
    logic [shift_width-1:0] t_shift [max_rows];
    alu_word_t              t_res   [max_rows];
    logic                   t_ne    [max_rows];
    logic                   t_lt    [max_rows];
    logic                   t_ovf   [max_rows];
    int                     n_rows;
    logic                   table_ready;

    integer seed;
    // failed checks of the test in progress
    int     errors;
    int     pass_count;
    int     fail_count;

    alu u_dut (
        .clock        (clock),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .op           (op),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .shift_amount (shift_amount),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .result       (result),
        .not_equal    (not_equal),
        .less_than    (less_than),
        .overflow     (overflow)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic add_row(input string name, input alu_op_e row_op, input alu_word_t a,
                           input alu_word_t b, input int sh, input alu_word_t res,
                           input logic ne, input logic lt, input logic ovf);
        t_name[n_rows]  = name;
        t_op[n_rows]    = row_op;
        t_a[n_rows]     = a;
        t_b[n_rows]     = b;
        t_shift[n_rows] = shift_width'(sh);
        t_res[n_rows]   = res;
        t_ne[n_rows]    = ne;
        t_lt[n_rows]    = lt;
        t_ovf[n_rows]   = ovf;
        n_rows++;
    endtask

    // columns: name, op, a, b, shift, result, not_equal, less_than, overflow
    task automatic build_table();
        add_row("add_small",     op_add, 32'h00000005, 32'h00000007, 0, 32'h0000000c, 1, 0, 0);
        add_row("add_pos_ovf",   op_add, 32'h7fffffff, 32'h00000001, 0, 32'h80000000, 1, 0, 1);
        add_row("add_neg_ovf",   op_add, 32'h80000000, 32'hffffffff, 0, 32'h7fffffff, 1, 1, 1);
        add_row("add_to_zero",   op_add, 32'hffffffff, 32'h00000001, 0, 32'h00000000, 0, 0, 0);
        add_row("sub_equal",     op_sub, 32'h12345678, 32'h12345678, 0, 32'h00000000, 0, 0, 0);
        add_row("sub_less",      op_sub, 32'h00000003, 32'h0000000a, 0, 32'hfffffff9, 1, 1, 0);
        add_row("sub_greater",   op_sub, 32'h0000000a, 32'h00000003, 0, 32'h00000007, 1, 0, 0);
        add_row("sub_pos_ovf",   op_sub, 32'h7fffffff, 32'hffffffff, 0, 32'h80000000, 1, 0, 1);
        add_row("sub_neg_ovf",   op_sub, 32'h80000000, 32'h00000001, 0, 32'h7fffffff, 1, 1, 1);
        // logic ops never raise a flag
        add_row("and_mask",      op_and, 32'hf0f01234, 32'h0ff0ff00, 0, 32'h00f01200, 0, 0, 0);
        add_row("or_mask",       op_or,  32'hf0f01234, 32'h0ff0ff00, 0, 32'hfff0ff34, 0, 0, 0);
        add_row("xor_mask",      op_xor, 32'hf0f01234, 32'h0ff0ff00, 0, 32'hff00ed34, 0, 0, 0);
        add_row("sll_0",         op_sll, 32'h12345678, 32'h00000000, 0, 32'h12345678, 0, 0, 0);
        add_row("sll_0_neg",     op_sll, 32'h87654321, 32'h00000000, 0, 32'h87654321, 0, 0, 0);
        add_row("sll_1",         op_sll, 32'h12345678, 32'h00000000, 1, 32'h2468acf0, 0, 0, 0);
        add_row("sll_1_neg",     op_sll, 32'h87654321, 32'h00000000, 1, 32'h0eca8642, 0, 0, 0);
        add_row("sll_16_pos",    op_sll, 32'h12345678, 32'h00000000, 16, 32'h56780000, 0, 0, 0);
        add_row("sll_16_neg",    op_sll, 32'h87654321, 32'h00000000, 16, 32'h43210000, 0, 0, 0);
        add_row("sll_31_pos",    op_sll, 32'h12345678, 32'h00000000, 31, 32'h00000000, 0, 0, 0);
        add_row("sll_31_neg",    op_sll, 32'h87654321, 32'h00000000, 31, 32'h80000000, 0, 0, 0);
        // right shifts copy the sign bit in
        add_row("sra_0_pos",     op_sra, 32'h12345678, 32'h00000000, 0, 32'h12345678, 0, 0, 0);
        add_row("sra_0_neg",     op_sra, 32'h87654321, 32'h00000000, 0, 32'h87654321, 0, 0, 0);
        add_row("sra_1_pos",     op_sra, 32'h12345678, 32'h00000000, 1, 32'h091a2b3c, 0, 0, 0);
        add_row("sra_1_neg",     op_sra, 32'h87654321, 32'h00000000, 1, 32'hc3b2a190, 0, 0, 0);
        add_row("sra_16_pos",    op_sra, 32'h12345678, 32'h00000000, 16, 32'h00001234, 0, 0, 0);
        add_row("sra_16_neg",    op_sra, 32'h87654321, 32'h00000000, 16, 32'hffff8765, 0, 0, 0);
        add_row("sra_31_pos",    op_sra, 32'h12345678, 32'h00000000, 31, 32'h00000000, 0, 0, 0);
        add_row("sra_31_neg",    op_sra, 32'h87654321, 32'h00000000, 31, 32'hffffffff, 0, 0, 0);
        add_row("mul_small",     op_mul, 32'h00000006, 32'h00000007, 0, 32'h0000002a, 0, 0, 0);
        add_row("mul_mixed",     op_mul, 32'hfffffffd, 32'h00000005, 0, 32'hfffffff1, 0, 0, 0);
        add_row("mul_neg_neg",   op_mul, 32'hfffffffc, 32'hfffffffa, 0, 32'h00000018, 0, 0, 0);
        // 2**32 and 2**31 do not fit a signed word
        add_row("mul_big",       op_mul, 32'h00010000, 32'h00010000, 0, 32'h00000000, 0, 0, 1);
        add_row("mul_to_sign",   op_mul, 32'h40000000, 32'h00000002, 0, 32'h80000000, 0, 0, 1);
        add_row("mul_min_one",   op_mul, 32'h80000000, 32'h00000001, 0, 32'h80000000, 0, 0, 0);
        // truncation toward zero
        add_row("div_pos_pos",   op_div, 32'h00000007, 32'h00000002, 0, 32'h00000003, 0, 0, 0);
        add_row("div_neg_pos",   op_div, 32'hfffffff9, 32'h00000002, 0, 32'hfffffffd, 0, 0, 0);
        add_row("div_pos_neg",   op_div, 32'h00000007, 32'hfffffffe, 0, 32'hfffffffd, 0, 0, 0);
        add_row("div_neg_neg",   op_div, 32'hfffffff9, 32'hfffffffe, 0, 32'h00000003, 0, 0, 0);
        add_row("div_large",     op_div, 32'h7fffffff, 32'h00000010, 0, 32'h07ffffff, 0, 0, 0);
        add_row("div_by_zero",   op_div, 32'h00000064, 32'h00000000, 0, 32'h00000000, 0, 0, 1);
        add_row("div_min_neg1",  op_div, 32'h80000000, 32'hffffffff, 0, 32'h80000000, 0, 0, 1);
    endtask

    task automatic check_word(input string name, input alu_word_t expected,
                              input alu_word_t actual);
        if (actual !== expected) begin
            $display("** Error %s result: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input string flag_name,
                              input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error %s %s: expected %b, actual %b", name, flag_name,
                     expected, actual);
            errors++;
        end
    endtask

    // one falling edge, out_ready gets a fresh random value
    task automatic next_cycle();
        integer draw;
        @(negedge clock);
        draw      = $random(seed);
        out_ready = draw[0];
    endtask

    task automatic report_test(input string name);
        if (errors == 0) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", name, errors);
        end
    endtask

    task automatic run_row(input int i);
        logic busy_seen;
        errors    = 0;
        busy_seen = 1'b0;
        next_cycle();
        in_valid     = 1'b1;
        op           = t_op[i];
        operand_a    = t_a[i];
        operand_b    = t_b[i];
        shift_amount = t_shift[i];
        // in_ready only moves on a rising edge, stable here
        while (in_ready !== 1'b1) begin
            next_cycle();
        end
        if (out_valid !== 1'b0) begin
            $display("%s: out_valid was high before the operation was accepted", t_name[i]);
            errors++;
        end
        // transfer on the coming rising edge
        next_cycle();
        in_valid = 1'b0;
        while (!(out_valid === 1'b1 && out_ready === 1'b1)) begin
            if (in_ready !== 1'b0 && !busy_seen) begin
                $display("%s: in_ready rose before the result was taken", t_name[i]);
                busy_seen = 1'b1;
                errors++;
            end
            next_cycle();
        end
        // result is taken on the next rising edge
        check_word(t_name[i], t_res[i], result);
        check_flag(t_name[i], "not_equal", t_ne[i], not_equal);
        check_flag(t_name[i], "less_than", t_lt[i], less_than);
        check_flag(t_name[i], "overflow", t_ovf[i], overflow);
        report_test(t_name[i]);
    endtask

    initial begin
        seed         = 32'h8851_05d7;
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        op           = op_add;
        operand_a    = '0;
        operand_b    = '0;
        shift_amount = '0;
        out_ready    = 1'b0;
        pass_count   = 0;
        fail_count   = 0;
        n_rows       = 0;
        table_ready  = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        // idle straight out of reset
        errors = 0;
        check_flag("reset", "in_ready", 1'b1, in_ready);
        check_flag("reset", "out_valid", 1'b0, out_valid);
        report_test("reset");
        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end
        $display("passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // budget per row covers the slowest op plus back-pressure stalls
    initial begin
        wait (table_ready === 1'b1);
        #(n_rows * (muldiv_steps + 20) * 40 * 4);
        $display("watchdog: the DUT stopped responding, run ended at %0t", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
source/alu_pkg.sv
source/cla_adder.sv
source/barrel_shifter.sv
source/multiplier.sv
source/divider.sv
source/alu.sv
verification/alu_tb.sv
